// File: common/fme_macros.svh
// fme sizes and register map shared by the interpolation unit and its bench

`ifndef FME_MACROS_SVH
`define FME_MACROS_SVH

// ******************************
// data sizes
// ******************************
`define FME_PIXEL_WIDTH 8      // luma sample
`define FME_BLK         4      // predicted block edge
`define FME_TAPS        8      // luma filter length
`define FME_WIN         11     // reference window edge, blk + taps - 1

// ******************************
// register map, 12-bit byte addresses
// ******************************
`define FME_REG_CTRL    (12'h000)  // bit 0 start, frac_x 5:4, frac_y 9:8
`define FME_REG_STATUS  (12'h004)  // bit 0 busy, bit 1 sticky done

// window row r, word w at base + 16r + 4w
// byte k of a word is column 4w+k, column 11 dropped
`define FME_WIN_BASE    (12'h100)

// result row r at base + 4r, byte c is column c
`define FME_BLK_BASE    (12'h200)

`endif

// File: common/axil_pkg.sv
// axi4-lite channel bundles between the host and the register block

package axil_pkg;

	// ******************************
	// master to slave
	// ******************************
	typedef struct packed {
		logic [11:0] awaddr;   // byte address
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;    // one bit per byte lane
		logic        wvalid;
		logic        bready;
		logic [11:0] araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	// ******************************
	// slave to master
	// ******************************
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;    // always okay
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

endpackage

// File: common/fme_pkg.sv
// fme types and luma quarter-pel filter coefficients

`include "fme_macros.svh"

package fme_pkg;

	typedef logic [1:0] frac_t;            // quarter-pel position 0..3

	typedef enum logic {
		PASS_H = 1'b0,                     // rows into intermediates
		PASS_V = 1'b1                      // intermediates into pixels
	} pass_t;

	typedef struct packed {
		frac_t frac_x;
		frac_t frac_y;
	} fme_cfg_t;

	typedef logic signed [15:0] tap_t;
	typedef tap_t [`FME_TAPS-1:0] fme_taps_t;   // element 0 is tap 0

	// window and block indexed [row][col]
	typedef logic [`FME_WIN-1:0][`FME_WIN-1:0][`FME_PIXEL_WIDTH-1:0] fme_win_t;
	typedef logic [`FME_BLK-1:0][`FME_BLK-1:0][`FME_PIXEL_WIDTH-1:0] fme_blk_t;

	// ******************************
	// hevc luma weights per fraction
	// ******************************
	// concatenations list tap 7 first
	function automatic fme_taps_t fme_coef(frac_t frac);
		fme_taps_t c;
		case (frac)
			2'd1: c = {16'sd0, 16'sd1, -16'sd5, 16'sd17,
				16'sd58, -16'sd10, 16'sd4, -16'sd1};
			2'd2: c = {-16'sd1, 16'sd4, -16'sd11, 16'sd40,
				16'sd40, -16'sd11, 16'sd4, -16'sd1};
			2'd3: c = {-16'sd1, 16'sd4, -16'sd10, 16'sd58,
				16'sd17, -16'sd5, 16'sd1, 16'sd0};
			default: c = {16'sd0, 16'sd0, 16'sd0, 16'sd0,
				16'sd64, 16'sd0, 16'sd0, 16'sd0};  // integer position, copy tap 3
		endcase
		return c;
	endfunction

endpackage

// File: fme/fme_interpolator.sv
// fme interpolator, one 8-tap quarter-pel filter shared by both passes

`include "fme_macros.svh"

module fme_interpolator import fme_pkg::*; (
	input  fme_taps_t          taps_i,   // samples or intermediates
	input  frac_t              frac_i,
	input  pass_t              pass_i,
	output logic signed [15:0] val_o
);

	fme_taps_t                    coef;
	logic signed [31:0]           sum;     // weighted sum, full precision
	logic signed [31:0]           vsum;    // vertical result before clip
	logic [`FME_PIXEL_WIDTH-1:0]  pix;

	// ******************************
	// weighted sum
	// ******************************
	always_comb begin
		coef = fme_coef(frac_i);
		sum = '0;
		for (int k = 0; k < `FME_TAPS; k++) begin
			sum = sum + taps_i[k] * coef[k];
		end
	end

	// second pass drops both the -8192 bias and the 12-bit gain
	// 526336 = 64 * 8192 + 2048 for rounding
	assign vsum = (sum + 32'sd526336) >>> 12;

	// clip to the pixel range
	always_comb begin
		if (vsum < 0) begin
			pix = '0;
		end else if (vsum > 255) begin
			pix = '1;
		end else begin
			pix = vsum[`FME_PIXEL_WIDTH-1:0];
		end
	end

	always_comb begin
		if (pass_i == PASS_H) begin
			val_o = 16'(sum - 32'sd8192);   // biased to fit 16 bits
		end else begin
			val_o = $signed(16'(pix));
		end
	end

endmodule

// File: fme/fme_engine.sv
// fme engine, horizontal then vertical pass over the window with one filter

`include "fme_macros.svh"

module fme_engine import fme_pkg::*; (
	input  logic     clk,
	input  logic     reset_i,
	input  logic     start_i,   // single-cycle pulse, ignored while busy
	input  fme_cfg_t cfg_i,     // held by the register block while busy
	input  fme_win_t win_i,
	output logic     busy_o,
	output logic     done_o,    // high on the last vertical cycle
	output fme_blk_t blk_o
);

	localparam int ROW_W = $clog2(`FME_WIN);
	localparam int COL_W = $clog2(`FME_BLK);

	logic               busy_q;
	pass_t              pass_q;
	logic [ROW_W-1:0]   row_q;
	logic [COL_W-1:0]   col_q;
	logic               last_row;

	logic signed [15:0] inter [`FME_WIN][`FME_BLK];   // horizontal results
	fme_blk_t           blk_q;

	fme_taps_t          taps;
	frac_t              frac;
	logic signed [15:0] val;

	// ******************************
	// pass sequencing
	// ******************************
	// 11 rows of 4 in the first pass, then 4 rows of 4
	assign last_row = (pass_q == PASS_H) ? (row_q == ROW_W'(`FME_WIN - 1))
		: (row_q == ROW_W'(`FME_BLK - 1));

	always_ff @(posedge clk) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			pass_q <= PASS_H;
			row_q  <= '0;
			col_q  <= '0;
		end else if (!busy_q) begin
			if (start_i) begin
				busy_q <= 1'b1;
				pass_q <= PASS_H;
				row_q  <= '0;
				col_q  <= '0;
			end
		end else begin
			col_q <= col_q + 1'b1;   // wraps at block edge
			if (col_q == COL_W'(`FME_BLK - 1)) begin
				if (!last_row) begin
					row_q <= row_q + 1'b1;
				end else if (pass_q == PASS_H) begin
					pass_q <= PASS_V;
					row_q  <= '0;
				end else begin
					busy_q <= 1'b0;   // block complete
				end
			end
		end
	end

	assign done_o = busy_q && (pass_q == PASS_V) && last_row
		&& (col_q == COL_W'(`FME_BLK - 1));
	assign busy_o = busy_q;

	// ******************************
	// tap selection
	// ******************************
	always_comb begin
		for (int k = 0; k < `FME_TAPS; k++) begin
			if (pass_q == PASS_H) begin
				taps[k] = 16'(win_i[row_q][col_q + k]);     // pixels along the row
			end else begin
				taps[k] = inter[row_q + k][col_q];          // intermediates down the column
			end
		end
	end

	assign frac = (pass_q == PASS_H) ? cfg_i.frac_x : cfg_i.frac_y;

	fme_interpolator u_interp (
		.taps_i (taps),
		.frac_i (frac),
		.pass_i (pass_q),
		.val_o  (val)
	);

	// ******************************
	// result buffers
	// ******************************
	always_ff @(posedge clk) begin
		if (busy_q) begin
			if (pass_q == PASS_H) begin
				inter[row_q][col_q] <= val;
			end else begin
				blk_q[row_q][col_q] <= val[`FME_PIXEL_WIDTH-1:0];
			end
		end
	end

	assign blk_o = blk_q;

endmodule

// File: src/fme_regs.sv
// fme register block, axi4-lite slave holding window, control, status and result readout

`include "fme_macros.svh"

module fme_regs import axil_pkg::*, fme_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  axil_req_t axil_req_i,
	output axil_rsp_t axil_rsp_o,
	input  logic      busy_i,
	input  logic      done_i,
	input  fme_blk_t  blk_i,
	output fme_win_t  win_o,
	output fme_cfg_t  cfg_o,
	output logic      start_o
);

	logic        wr_ready_q;   // awready and wready together
	logic        bvalid_q;
	logic        rvalid_q;
	logic [31:0] rdata_q;
	logic        wr_en;
	logic        rd_en;
	logic        win_we;
	logic [31:0] rd_word;

	fme_cfg_t    cfg_q;
	logic        done_q;       // sticky until the next start
	fme_win_t    win_q;

	// ******************************
	// write channel
	// ******************************
	assign wr_en = wr_ready_q && axil_req_i.awvalid && axil_req_i.wvalid;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ready_q <= 1'b0;
			bvalid_q   <= 1'b0;
		end else begin
			// ready for one cycle once address and data are both present
			wr_ready_q <= axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q
				&& !wr_ready_q;
			if (wr_en) begin
				bvalid_q <= 1'b1;
			end else if (axil_req_i.bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	assign start_o = wr_en && (axil_req_i.awaddr == `FME_REG_CTRL)
		&& axil_req_i.wstrb[0] && axil_req_i.wdata[0] && !busy_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			cfg_q  <= '0;
			done_q <= 1'b0;
		end else begin
			// fractions stay frozen while the engine runs
			if (wr_en && (axil_req_i.awaddr == `FME_REG_CTRL) && !busy_i) begin
				if (axil_req_i.wstrb[0]) cfg_q.frac_x <= axil_req_i.wdata[5:4];
				if (axil_req_i.wstrb[1]) cfg_q.frac_y <= axil_req_i.wdata[9:8];
			end
			if (start_o) begin
				done_q <= 1'b0;
			end else if (done_i) begin
				done_q <= 1'b1;
			end
		end
	end

	// window rows are 16 bytes apart
	assign win_we = wr_en && !busy_i && (axil_req_i.awaddr >= `FME_WIN_BASE)
		&& (axil_req_i.awaddr < `FME_WIN_BASE + 16 * `FME_WIN);

	always_ff @(posedge clk) begin
		if (win_we) begin
			for (int k = 0; k < 4; k++) begin
				if (axil_req_i.wstrb[k] && (4 * axil_req_i.awaddr[3:2] + k) < `FME_WIN) begin
					win_q[axil_req_i.awaddr[7:4]][4 * axil_req_i.awaddr[3:2] + k]
						<= axil_req_i.wdata[8*k +: 8];
				end
			end
		end
	end

	// ******************************
	// read channel
	// ******************************
	assign rd_en = axil_req_i.arvalid && !rvalid_q;

	always_comb begin
		rd_word = '0;   // unmapped
		if (axil_req_i.araddr == `FME_REG_CTRL) begin
			rd_word = {22'd0, cfg_q.frac_y, 2'b00, cfg_q.frac_x, 4'h0};
		end else if (axil_req_i.araddr == `FME_REG_STATUS) begin
			rd_word = {30'd0, done_q, busy_i};
		end else if ((axil_req_i.araddr >= `FME_BLK_BASE)
			&& (axil_req_i.araddr < `FME_BLK_BASE + 4 * `FME_BLK)) begin
			rd_word = blk_i[axil_req_i.araddr[3:2]];   // column c in byte c
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rvalid_q <= 1'b0;
		end else if (rd_en) begin
			rvalid_q <= 1'b1;
		end else if (axil_req_i.rready) begin
			rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) rdata_q <= rd_word;   // held until rready
	end

	always_comb begin
		axil_rsp_o         = '0;
		axil_rsp_o.awready = wr_ready_q;
		axil_rsp_o.wready  = wr_ready_q;
		axil_rsp_o.bvalid  = bvalid_q;
		axil_rsp_o.bresp   = 2'b00;
		axil_rsp_o.arready = !rvalid_q;
		axil_rsp_o.rvalid  = rvalid_q;
		axil_rsp_o.rdata   = rdata_q;
		axil_rsp_o.rresp   = 2'b00;
	end

	assign win_o = win_q;
	assign cfg_o = cfg_q;

endmodule

// File: src/fme_top.sv
// fme top, axi4-lite register block feeding the two-pass interpolation engine

module fme_top import axil_pkg::*, fme_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  axil_req_t axil_req_i,
	output axil_rsp_t axil_rsp_o
);

	fme_win_t win;
	fme_cfg_t cfg;
	fme_blk_t blk;
	logic     start;
	logic     busy;
	logic     done;

	fme_regs u_regs (
		.clk        (clk),
		.reset_i    (reset_i),
		.axil_req_i (axil_req_i),
		.axil_rsp_o (axil_rsp_o),
		.busy_i     (busy),
		.done_i     (done),
		.blk_i      (blk),
		.win_o      (win),
		.cfg_o      (cfg),
		.start_o    (start)
	);

	fme_engine u_engine (
		.clk     (clk),
		.reset_i (reset_i),
		.start_i (start),
		.cfg_i   (cfg),
		.win_i   (win),
		.busy_o  (busy),
		.done_o  (done),
		.blk_o   (blk)
	);

endmodule

// File: bench/fme_clkgen.sv
// fme bench clock and reset source, 100 ns period with a 4-cycle reset

module fme_clkgen (
	output logic clk_o,
	output logic reset_o
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o   = 1'b0;
		reset_o = 1'b1;
		repeat (4) @(posedge clk_o);
		reset_o <= 1'b0;   // released on the fourth edge
	end

	always #50 clk_o = ~clk_o;

endmodule

// File: bench/fme_assert.sv
// fme protocol checker for the axi4-lite responses and the done pulse

module fme_assert import axil_pkg::*; (
	input logic      clk,
	input logic      reset_i,
	input axil_req_t req_i,
	input axil_rsp_t rsp_i,
	input logic      done_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// ******************************
	// response channels
	// ******************************
	bvalid_hold: assert property (@(posedge clk) disable iff (reset_i)
		rsp_i.bvalid && !req_i.bready |=> rsp_i.bvalid)
		else $error("write response dropped before bready");

	rdata_hold: assert property (@(posedge clk) disable iff (reset_i)
		rsp_i.rvalid && !req_i.rready |=> rsp_i.rvalid && $stable(rsp_i.rdata))
		else $error("read response changed before rready");

	// engine completion is a single-cycle pulse
	done_pulse: assert property (@(posedge clk) disable iff (reset_i)
		done_i |=> !done_i)
		else $error("done high for two cycles");

endmodule

// File: bench/fme_tb.sv
// fme testbench, loads windows over axi4-lite and checks predicted blocks

`include "fme_macros.svh"

module fme_tb import axil_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 16;    // cycles per handshake
	localparam int POLL_LIMIT = 64;    // status reads per run
	localparam int FILL_RANDOM = 0;
	localparam int FILL_WHITE = 1;
	localparam int FILL_BLACK = 2;
	localparam int FILL_STRIPES = 3;

	logic        clk;
	logic        reset;
	axil_req_t   req;
	axil_rsp_t   rsp;

	logic [31:0] rng;
	logic [7:0]  win_model [11][11];
	logic [7:0]  got_pix [4][4];
	logic [7:0]  exp_pix [4][4];
	int          errors;
	int          checks;
	int          err_mark;
	int          test_no;
	int          bp_cycles;        // back-pressure on b and r
	logic        timed_out;
	logic        cmp_pending;

	fme_clkgen u_clkgen (
		.clk_o   (clk),
		.reset_o (reset)
	);

	fme_top UUT (
		.clk        (clk),
		.reset_i    (reset),
		.axil_req_i (req),
		.axil_rsp_o (rsp)
	);

	bind fme_regs fme_assert u_assert (
		.clk     (clk),
		.reset_i (reset_i),
		.req_i   (axil_req_i),
		.rsp_i   (axil_rsp_o),
		.done_i  (done_i)
	);

	// ******************************
	// helpers
	// ******************************
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int filter_weight(input int frac, input int k);
		int quarter [8];
		int half [8];
		quarter = '{-1, 4, -10, 58, 17, -5, 1, 0};
		half = '{-1, 4, -11, 40, 40, -11, 4, -1};
		case (frac)
			1: return quarter[k];
			2: return half[k];
			3: return quarter[7 - k];   // mirror of the quarter filter
			default: return (k == 3) ? 64 : 0;
		endcase
	endfunction

	// two-pass rule on the bench copy of the window
	function automatic void predict_block(input int fx, input int fy);
		int inter [11][4];
		int sum;
		for (int r = 0; r < 11; r++) begin
			for (int c = 0; c < 4; c++) begin
				sum = 0;
				for (int k = 0; k < 8; k++) begin
					sum += int'(win_model[r][c + k]) * filter_weight(fx, k);
				end
				inter[r][c] = sum - 8192;
			end
		end
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				sum = 0;
				for (int k = 0; k < 8; k++) begin
					sum += inter[r + k][c] * filter_weight(fy, k);
				end
				sum = (sum + 526336) >>> 12;
				exp_pix[r][c] = (sum < 0) ? 8'd0 : (sum > 255) ? 8'd255 : 8'(sum);
			end
		end
	endfunction

	function automatic logic [31:0] ctrl_word(input int fx, input int fy);
		return 32'((fx << 4) | (fy << 8));
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	// ******************************
	// axi4-lite master
	// ******************************
	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int n;
		if (timed_out) return;
		@(posedge clk);
		req.awaddr  <= addr;
		req.awvalid <= 1'b1;
		req.wdata   <= data;
		req.wstrb   <= strb;
		req.wvalid  <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!(rsp.awready && rsp.wready) && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		@(posedge clk);
		req.awvalid <= 1'b0;
		req.wvalid  <= 1'b0;
		if (n >= WAIT_LIMIT) begin
			report_timeout("awready and wready");
			return;
		end
		n = 0;
		@(negedge clk);
		while (!rsp.bvalid && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			report_timeout("bvalid");
			return;
		end
		check_value("bresp", rsp.bresp, 32'h0);
		for (int i = 0; i < bp_cycles; i++) begin
			@(negedge clk);
			check_value("bvalid", rsp.bvalid, 32'h1);   // held under back-pressure
		end
		@(posedge clk);
		req.bready <= 1'b1;
		@(posedge clk);
		req.bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
		int n;
		data = '0;
		if (timed_out) return;
		@(posedge clk);
		req.araddr  <= addr;
		req.arvalid <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!rsp.arready && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		@(posedge clk);
		req.arvalid <= 1'b0;
		if (n >= WAIT_LIMIT) begin
			report_timeout("arready");
			return;
		end
		n = 0;
		@(negedge clk);
		while (!rsp.rvalid && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			report_timeout("rvalid");
			return;
		end
		data = rsp.rdata;
		check_value("rresp", rsp.rresp, 32'h0);
		for (int i = 0; i < bp_cycles; i++) begin
			@(negedge clk);
			check_value("rdata", rsp.rdata, data);
		end
		@(posedge clk);
		req.rready <= 1'b1;
		@(posedge clk);
		req.rready <= 1'b0;
	endtask

	// ******************************
	// block runs
	// ******************************
	task automatic fill_window(input int mode);
		for (int r = 0; r < 11; r++) begin
			for (int c = 0; c < 11; c++) begin
				rng = xorshift32(rng);
				case (mode)
					FILL_WHITE: win_model[r][c] = 8'hff;
					FILL_BLACK: win_model[r][c] = 8'h00;
					FILL_STRIPES: win_model[r][c] = ((c / 2) % 2 == 1) ? 8'hff : 8'h00;
					default: win_model[r][c] = rng[7:0];
				endcase
			end
		end
	endtask

	task automatic load_window();
		logic [31:0] word;
		for (int r = 0; r < 11; r++) begin
			for (int w = 0; w < 3; w++) begin
				word = '0;
				for (int k = 0; k < 4; k++) begin
					if (4 * w + k < 11) word[8*k +: 8] = win_model[r][4 * w + k];
				end
				axi_write(12'(`FME_WIN_BASE + 16 * r + 4 * w), word, 4'hf);
			end
		end
	endtask

	task automatic run_block(input int fx, input int fy);
		logic [31:0] status;
		logic [31:0] row;
		int n;
		load_window();
		axi_write(`FME_REG_CTRL, ctrl_word(fx, fy) | 32'h1, 4'b0011);
		status = '0;
		n = 0;
		while (!status[1] && !timed_out && n < POLL_LIMIT) begin
			axi_read(`FME_REG_STATUS, status);
			n++;
		end
		if (!status[1] && !timed_out) report_timeout("the done bit");
		for (int r = 0; r < 4; r++) begin
			axi_read(12'(`FME_BLK_BASE + 4 * r), row);
			for (int c = 0; c < 4; c++) got_pix[r][c] = row[8*c +: 8];
		end
	endtask

	// hand the block to the comparing process
	task automatic compare_block();
		int n;
		if (timed_out) return;
		cmp_pending = 1'b1;
		n = 0;
		while (cmp_pending && n < 4) begin
			@(posedge clk);
			n++;
		end
		if (cmp_pending) report_timeout("the block comparison");
	endtask

	always @(negedge clk) begin
		if (cmp_pending) begin
			for (int r = 0; r < 4; r++) begin
				for (int c = 0; c < 4; c++) begin
					checks++;
					assert (got_pix[r][c] == exp_pix[r][c]) else begin
						$display("mismatch blk_pixel[%0d][%0d] got %h expected %h",
							r, c, got_pix[r][c], exp_pix[r][c]);
						errors++;
					end
				end
			end
			cmp_pending = 1'b0;
		end
	end

	task automatic end_test(input string name);
		test_no++;
		$display("test %0d %s: %s, %0d errors", test_no, name,
			(errors == err_mark) ? "pass" : "fail", errors - err_mark);
		err_mark = errors;
	endtask

	// ******************************
	// test sequence
	// ******************************
	initial begin
		logic [31:0] word;
		int n;
		int fx;
		int fy;
		req = '0;
		rng = 32'h4b;
		errors = 0;
		checks = 0;
		err_mark = 0;
		test_no = 0;
		bp_cycles = 0;
		timed_out = 1'b0;
		cmp_pending = 1'b0;
		n = 0;
		@(negedge clk);
		while (reset && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (reset) report_timeout("reset release");

		fill_window(FILL_RANDOM);
		run_block(0, 0);
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) exp_pix[r][c] = win_model[3 + r][3 + c];
		end
		compare_block();
		end_test("integer position");

		for (int f = 1; f < 4; f++) begin
			fill_window(FILL_RANDOM);
			run_block(f, 0);
			predict_block(f, 0);
			compare_block();
		end
		end_test("horizontal only");

		for (int f = 1; f < 4; f++) begin
			fill_window(FILL_RANDOM);
			run_block(0, f);
			predict_block(0, f);
			compare_block();
		end
		end_test("vertical only");

		for (int i = 0; i < 8; i++) begin
			rng = xorshift32(rng);
			fx = int'(rng % 3) + 1;
			rng = xorshift32(rng);
			fy = int'(rng % 3) + 1;
			fill_window(FILL_RANDOM);
			run_block(fx, fy);
			predict_block(fx, fy);
			compare_block();
			axi_read(`FME_REG_CTRL, word);
			check_value("ctrl", word, ctrl_word(fx, fy));
			axi_read(`FME_REG_STATUS, word);
			check_value("status", word, 32'h2);   // done, not busy
		end
		end_test("random fractions");

		fill_window(FILL_WHITE);
		run_block(1, 2);
		predict_block(1, 2);
		compare_block();
		fill_window(FILL_BLACK);
		run_block(2, 3);
		predict_block(2, 3);
		compare_block();
		// half-pel across column pairs overshoots below 0 and above 255
		fill_window(FILL_STRIPES);
		run_block(2, 1);
		predict_block(2, 1);
		compare_block();
		end_test("extreme windows");

		bp_cycles = 5;
		fill_window(FILL_RANDOM);
		run_block(2, 1);
		predict_block(2, 1);
		compare_block();
		axi_read(12'h080, word);
		check_value("unmapped rdata", word, 32'h0);
		axi_write(12'h0f0, 32'hdeadbeef, 4'hf);
		bp_cycles = 0;
		end_test("back-pressure");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
common/axil_pkg.sv
common/fme_pkg.sv
fme/fme_interpolator.sv
fme/fme_engine.sv
src/fme_regs.sv
src/fme_top.sv
bench/fme_clkgen.sv
bench/fme_assert.sv
bench/fme_tb.sv

// File: run.sh
#!/bin/sh
# build the fme testbench with verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module fme_tb -Mdir obj_dir -o fme_sim

./obj_dir/fme_sim | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
